//--- cpu_pkg.sv
package cpu_pkg;

   // ################################################
   // widths
   // ################################################
   localparam int XLEN       = 32;                    // data path width
   localparam int REG_ADDR_W = 5;                     // 32 architectural regs

   // ################################################
   // rv32i encodings
   // ################################################
   localparam logic [6:0] OPC_OP     = 7'b0110011;    // register-register group
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;    // register-immediate group

   localparam logic [2:0] F3_ADD_SUB = 3'b000;        // add / sub / addi
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;        // split by funct7
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   localparam logic [6:0] F7_BASE    = 7'b0000000;    // plain encoding
   localparam logic [6:0] F7_ALT     = 7'b0100000;    // sub, sra, srai

   // ################################################
   // alu controls
   // ################################################
   typedef enum logic [3:0] {
      ALU_NOP,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      SEL_NONE,                                       // no result, illegal or idle
      SEL_LOGIC,
      SEL_SHIFT,
      SEL_ARITH
   } alu_sel_e;

   // ################################################
   // stage payloads
   // ################################################
   typedef struct packed {
      alu_op_e                aluop;
      alu_sel_e               alusel;
      logic [XLEN-1:0]        reg1;                   // forwarded rs1
      logic [XLEN-1:0]        reg2;                   // rs2, imm or shamt
      logic [REG_ADDR_W-1:0]  wd;                     // destination reg
      logic                   wreg;                   // writes rd
      logic                   valid;
      logic                   illegal;
   } id_ex_t;

   typedef struct packed {
      logic [REG_ADDR_W-1:0]  wd;
      logic                   wreg;
      logic [XLEN-1:0]        wdata;                  // alu result
      logic                   valid;
      logic                   illegal;
   } ex_wb_t;

endpackage

//--- regfile.sv
`timescale 1ns/1ps

module regfile #(
   parameter int NUM_REGS = 32                        // depth set from the top
) (
   input  logic                              clk,
   input  logic                              reset_i,
   input  logic [cpu_pkg::REG_ADDR_W-1:0]    raddr1_i,    // rs1 port
   input  logic [cpu_pkg::REG_ADDR_W-1:0]    raddr2_i,    // rs2 port
   input  logic [cpu_pkg::REG_ADDR_W-1:0]    dbg_addr_i,  // debug port
   input  logic [cpu_pkg::REG_ADDR_W-1:0]    waddr_i,
   input  logic                              we_i,
   input  logic [cpu_pkg::XLEN-1:0]          wdata_i,
   output logic [cpu_pkg::XLEN-1:0]          rdata1_o,
   output logic [cpu_pkg::XLEN-1:0]          rdata2_o,
   output logic [cpu_pkg::XLEN-1:0]          dbg_data_o
);

   logic [cpu_pkg::XLEN-1:0] regs [NUM_REGS];        // storage incl. x0

   // x0 and out-of-range addresses read as zero
   function automatic logic [cpu_pkg::XLEN-1:0] rd_reg(
      input logic [cpu_pkg::REG_ADDR_W-1:0] addr
   );
      if (addr == '0 || int'(addr) >= NUM_REGS)
         return '0;
      return regs[addr];
   endfunction

   // ################################################
   // write port
   // ################################################
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;                            // all regs cleared
      end
      else if (we_i && waddr_i != '0 && int'(waddr_i) < NUM_REGS)
      begin
         regs[waddr_i] <= wdata_i;                    // x0 writes dropped
      end
   end

   assign rdata1_o   = rd_reg(raddr1_i);              // combinational reads
   assign rdata2_o   = rd_reg(raddr2_i);
   assign dbg_data_o = rd_reg(dbg_addr_i);            // new value seen after the edge

   // x0 storage stays zero whatever the write traffic
   a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
      we_i && waddr_i == '0 |=> regs[0] == '0);

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
   input  logic                              clk,
   input  logic                              reset_i,
   input  logic                              instr_valid_i,  // one-cycle strobe
   input  logic [cpu_pkg::XLEN-1:0]          instr_i,
   input  cpu_pkg::ex_wb_t                   fwd_i,          // result now in execute
   output logic [cpu_pkg::REG_ADDR_W-1:0]    rs1_addr_o,
   output logic [cpu_pkg::REG_ADDR_W-1:0]    rs2_addr_o,
   input  logic [cpu_pkg::XLEN-1:0]          rs1_data_i,
   input  logic [cpu_pkg::XLEN-1:0]          rs2_data_i,
   output cpu_pkg::id_ex_t                   id_ex_o
);

   logic [6:0]                opcode;
   logic [2:0]                funct3;
   logic [6:0]                funct7;
   logic                      is_op, is_imm, alt, f7_ok;
   logic                      fwd_ok, hit1, hit2;
   logic [cpu_pkg::XLEN-1:0]  op1, op2, imm_sext, shamt;
   cpu_pkg::id_ex_t           dec;                     // next id/ex contents

   // ################################################
   // field extraction
   // ################################################
   assign opcode     = instr_i[6:0];
   assign funct3     = instr_i[14:12];
   assign funct7     = instr_i[31:25];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];
   assign imm_sext   = {{(cpu_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};  // i-type imm
   assign shamt      = {{(cpu_pkg::XLEN-5){1'b0}}, instr_i[24:20]};          // slli/srli/srai

   assign is_op  = opcode == cpu_pkg::OPC_OP;
   assign is_imm = opcode == cpu_pkg::OPC_OP_IMM;
   assign alt    = funct7 == cpu_pkg::F7_ALT;

   // ################################################
   // forwarding from execute
   // ################################################
   assign fwd_ok = fwd_i.valid && fwd_i.wreg && fwd_i.wd != '0;  // x0 never forwarded
   assign hit1   = fwd_ok && fwd_i.wd == rs1_addr_o;
   assign hit2   = fwd_ok && fwd_i.wd == rs2_addr_o;
   assign op1    = hit1 ? fwd_i.wdata : rs1_data_i;
   assign op2    = hit2 ? fwd_i.wdata : rs2_data_i;

   // funct7 rules: alt only on add/sub and the right shifts
   always_comb
   begin
      if (is_op)
         f7_ok = funct7 == cpu_pkg::F7_BASE ||
                 (alt && (funct3 == cpu_pkg::F3_ADD_SUB || funct3 == cpu_pkg::F3_SRL_SRA));
      else if (funct3 == cpu_pkg::F3_SLL)
         f7_ok = funct7 == cpu_pkg::F7_BASE;        // slli
      else if (funct3 == cpu_pkg::F3_SRL_SRA)
         f7_ok = funct7 == cpu_pkg::F7_BASE || alt;   // srli / srai
      else
         f7_ok = 1'b1;                                // funct7 holds imm bits here
   end

   // ################################################
   // decode
   // ################################################
   always_comb
   begin
      dec         = '0;
      dec.valid   = instr_valid_i;
      dec.wd      = instr_i[11:7];
      dec.reg1    = op1;
      dec.reg2    = is_op ? op2 : imm_sext;
      dec.illegal = !((is_op || is_imm) && f7_ok);
      dec.wreg    = !dec.illegal;                     // illegal never writes
      case (funct3)
         cpu_pkg::F3_ADD_SUB: dec.aluop = (is_op && alt) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
         cpu_pkg::F3_SLL:     dec.aluop = cpu_pkg::ALU_SLL;
         cpu_pkg::F3_SLT:     dec.aluop = cpu_pkg::ALU_SLT;
         cpu_pkg::F3_SLTU:    dec.aluop = cpu_pkg::ALU_SLTU;
         cpu_pkg::F3_XOR:     dec.aluop = cpu_pkg::ALU_XOR;
         cpu_pkg::F3_SRL_SRA: dec.aluop = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
         cpu_pkg::F3_OR:      dec.aluop = cpu_pkg::ALU_OR;
         default:             dec.aluop = cpu_pkg::ALU_AND;
      endcase
      if (is_imm && (funct3 == cpu_pkg::F3_SLL || funct3 == cpu_pkg::F3_SRL_SRA))
         dec.reg2 = shamt;                            // shift by shamt, not imm
      if (dec.illegal)
         dec.aluop = cpu_pkg::ALU_NOP;
      case (dec.aluop)                                // result group from op
         cpu_pkg::ALU_NOP:                               dec.alusel = cpu_pkg::SEL_NONE;
         cpu_pkg::ALU_AND, cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR: dec.alusel = cpu_pkg::SEL_LOGIC;
         cpu_pkg::ALU_SLL, cpu_pkg::ALU_SRL, cpu_pkg::ALU_SRA: dec.alusel = cpu_pkg::SEL_SHIFT;
         default:                                        dec.alusel = cpu_pkg::SEL_ARITH;
      endcase
   end

   // id/ex register with only the control bits reset
   always_ff @(posedge clk)
   begin
      id_ex_o <= dec;
      if (reset_i)
      begin
         id_ex_o.valid   <= 1'b0;
         id_ex_o.wreg    <= 1'b0;
         id_ex_o.illegal <= 1'b0;
      end
   end

   // a legal strobe always lands in id/ex with a real result group
   a_legal_has_sel: assert property (@(posedge clk) disable iff (reset_i)
      instr_valid_i && !dec.illegal |=> id_ex_o.valid && id_ex_o.alusel != cpu_pkg::SEL_NONE);

endmodule

//--- ex.sv
`timescale 1ns/1ps

module ex (
   input  cpu_pkg::id_ex_t   id_ex_i,
   output cpu_pkg::ex_wb_t   ex_res_o
);

   localparam int SH_W = 5;                           // shamt bits for 32-bit data

   logic [cpu_pkg::XLEN-1:0]  reg1, reg2;
   logic [cpu_pkg::XLEN-1:0]  logic_res, shift_res, arith_res;
   logic [cpu_pkg::XLEN-1:0]  reg2_mux, result_sum;
   logic [SH_W-1:0]           sh;
   logic                      lt_signed, lt_unsigned;

   assign reg1 = id_ex_i.reg1;
   assign reg2 = id_ex_i.reg2;
   assign sh   = reg2[SH_W-1:0];                      // only low bits shift

   // ################################################
   // logic group
   // ################################################
   always_comb
   begin
      case (id_ex_i.aluop)
         cpu_pkg::ALU_AND: logic_res = reg1 & reg2;
         cpu_pkg::ALU_OR:  logic_res = reg1 | reg2;
         cpu_pkg::ALU_XOR: logic_res = reg1 ^ reg2;
         default:          logic_res = '0;
      endcase
   end

   // ################################################
   // shift group
   // ################################################
   always_comb
   begin
      case (id_ex_i.aluop)
         cpu_pkg::ALU_SLL: shift_res = reg1 << sh;
         cpu_pkg::ALU_SRL: shift_res = reg1 >> sh;
         cpu_pkg::ALU_SRA: shift_res = $signed(reg1) >>> sh;  // sign fill
         default:          shift_res = '0;
      endcase
   end

   // ################################################
   // arithmetic group
   // ################################################
   // sub and slt both add the negated reg2
   assign reg2_mux   = (id_ex_i.aluop == cpu_pkg::ALU_SUB || id_ex_i.aluop == cpu_pkg::ALU_SLT)
                       ? (~reg2) + 1'b1 : reg2;
   assign result_sum = reg1 + reg2_mux;

   // signed lt from operand signs and sign of the difference
   assign lt_signed   = (reg1[cpu_pkg::XLEN-1] && !reg2[cpu_pkg::XLEN-1]) ||
                        (!reg1[cpu_pkg::XLEN-1] && !reg2[cpu_pkg::XLEN-1] &&
                         result_sum[cpu_pkg::XLEN-1]) ||
                        (reg1[cpu_pkg::XLEN-1] && reg2[cpu_pkg::XLEN-1] &&
                         result_sum[cpu_pkg::XLEN-1]);
   assign lt_unsigned = reg1 < reg2;                  // plain magnitude compare

   always_comb
   begin
      case (id_ex_i.aluop)
         cpu_pkg::ALU_SLT:                  arith_res = {{(cpu_pkg::XLEN-1){1'b0}}, lt_signed};
         cpu_pkg::ALU_SLTU:                 arith_res = {{(cpu_pkg::XLEN-1){1'b0}}, lt_unsigned};
         cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: arith_res = result_sum;
         default:                           arith_res = '0;
      endcase
   end

   // ################################################
   // result select
   // ################################################
   always_comb
   begin
      ex_res_o.wd      = id_ex_i.wd;                  // control passes straight through
      ex_res_o.wreg    = id_ex_i.wreg;
      ex_res_o.valid   = id_ex_i.valid;
      ex_res_o.illegal = id_ex_i.illegal;
      case (id_ex_i.alusel)
         cpu_pkg::SEL_LOGIC: ex_res_o.wdata = logic_res;
         cpu_pkg::SEL_SHIFT: ex_res_o.wdata = shift_res;
         cpu_pkg::SEL_ARITH: ex_res_o.wdata = arith_res;
         default:            ex_res_o.wdata = '0;     // nop gives zero
      endcase
   end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
   input  logic                              clk,
   input  logic                              reset_i,
   input  cpu_pkg::ex_wb_t                   ex_res_i,
   output logic                              retire_o,       // one pulse per instr
   output logic                              retire_we_o,
   output logic                              illegal_o,
   output logic [cpu_pkg::REG_ADDR_W-1:0]    retire_rd_o,
   output logic [cpu_pkg::XLEN-1:0]          retire_data_o,
   output logic [cpu_pkg::XLEN-1:0]          instret_o       // legal retirements
);

   logic legal;

   assign legal = ex_res_i.valid && !ex_res_i.illegal;

   // ################################################
   // ex/wb register
   // ################################################
   always_ff @(posedge clk)
   begin
      retire_rd_o   <= ex_res_i.wd;                   // payload follows every cycle
      retire_data_o <= ex_res_i.wdata;
      if (reset_i)
      begin
         retire_o    <= 1'b0;
         retire_we_o <= 1'b0;
         illegal_o   <= 1'b0;
         instret_o   <= '0;
      end
      else
      begin
         retire_o    <= ex_res_i.valid;               // legal or illegal
         retire_we_o <= ex_res_i.valid && ex_res_i.wreg;
         illegal_o   <= ex_res_i.valid && ex_res_i.illegal;
         if (legal)
            instret_o <= instret_o + 1'b1;            // count legal only
      end
   end

   // a flagged illegal op never writes back
   a_illegal_no_write: assert property (@(posedge clk) disable iff (reset_i)
      !(illegal_o && retire_we_o));

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core #(
   parameter int NUM_REGS = 32                        // passed to regfile
) (
   input  logic                              clk,
   input  logic                              reset_i,
   input  logic                              instr_valid_i,
   input  logic [cpu_pkg::XLEN-1:0]          instr_i,
   input  logic [cpu_pkg::REG_ADDR_W-1:0]    dbg_addr_i,
   output logic [cpu_pkg::XLEN-1:0]          dbg_data_o,
   output logic                              retire_o,
   output logic [cpu_pkg::REG_ADDR_W-1:0]    retire_rd_o,
   output logic                              retire_we_o,
   output logic [cpu_pkg::XLEN-1:0]          retire_data_o,
   output logic                              illegal_o,
   output logic [cpu_pkg::XLEN-1:0]          instret_o
);

   logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr, rs2_addr;
   logic [cpu_pkg::XLEN-1:0]        rs1_data, rs2_data;
   cpu_pkg::id_ex_t                 id_ex;            // decode to execute
   cpu_pkg::ex_wb_t                 ex_res;           // to rf, wb and forwarding

   // ################################################
   // stages
   // ################################################
   regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
      .clk        (clk),
      .reset_i    (reset_i),
      .raddr1_i   (rs1_addr),
      .raddr2_i   (rs2_addr),
      .dbg_addr_i (dbg_addr_i),
      .waddr_i    (ex_res.wd),
      .we_i       (ex_res.wreg && ex_res.valid),     // write at end of execute
      .wdata_i    (ex_res.wdata),
      .rdata1_o   (rs1_data),
      .rdata2_o   (rs2_data),
      .dbg_data_o (dbg_data_o)
   );

   id_stage u_id_stage (
      .clk           (clk),
      .reset_i       (reset_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .fwd_i         (ex_res),                        // bypass path
      .rs1_addr_o    (rs1_addr),
      .rs2_addr_o    (rs2_addr),
      .rs1_data_i    (rs1_data),
      .rs2_data_i    (rs2_data),
      .id_ex_o       (id_ex)
   );

   ex u_ex (
      .id_ex_i  (id_ex),
      .ex_res_o (ex_res)
   );

   wb_stage u_wb_stage (
      .clk           (clk),
      .reset_i       (reset_i),
      .ex_res_i      (ex_res),
      .retire_o      (retire_o),
      .retire_we_o   (retire_we_o),
      .illegal_o     (illegal_o),
      .retire_rd_o   (retire_rd_o),
      .retire_data_o (retire_data_o),
      .instret_o     (instret_o)
   );

endmodule

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

   localparam int N_ISSUED   = 243;                   // instructions over all tests
   localparam int MAX_CYCLES = N_ISSUED * 3 + 100;    // room for gaps and read-backs

   typedef struct packed {
      logic [4:0]  rd;
      logic        we;
      logic [31:0] data;
      logic        illegal;
      logic [31:0] due;                               // cycle of the retire pulse
   } retire_t;                                        // one expected retirement

   logic        clk, reset_i, instr_valid_i;
   logic [31:0] instr_i, dbg_data_o, retire_data_o, instret_o;
   logic [4:0]  dbg_addr_i, retire_rd_o;
   logic        retire_o, retire_we_o, illegal_o;

   logic [31:0] model_regs [32] = '{default: '0};     // architectural state model
   retire_t     exp_q [$];                            // issued but not yet retired
   logic [31:0] lfsr;
   int          n_errors, n_checks, n_tests, n_failed, n_legal, last_errs, n_cycles;

   exec_core #(.NUM_REGS(32)) u_exec_core (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;                          // 10 ns period
   end

   // ################################################
   // model and helpers
   // ################################################
   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hB4BC_D35C : lfsr >> 1;
      end
      return v;
   endfunction

   // rv32i result by funct3
   function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub,
                                              input logic alt, input logic [31:0] a, b);
      case (f3)
         3'd0: return sub ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5:
         begin
            if (alt)
               return $signed(a) >>> b[4:0];          // sign fill
            return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         n_errors++;
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;                                             // drive point after the edge
   endtask

   // strobe one instruction and model it in program order
   task automatic issue(input logic [31:0] ins, input logic bad);
      logic        is_op;
      logic [31:0] a, b;
      retire_t     e;
      is_op     = ins[6:0] == cpu_pkg::OPC_OP;
      a         = model_regs[ins[19:15]];
      b         = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};  // rs2 or imm
      e.rd      = ins[11:7];
      e.illegal = bad;
      e.we      = !bad;
      e.data    = model_alu(ins[14:12], is_op && ins[30], ins[30], a, b);  // bit 30 is funct7 alt
      e.due     = 32'(n_cycles + 2);                  // latched next edge, retired the one after
      if (!bad && e.rd != '0)
         model_regs[e.rd] = e.data;                   // x0 stays zero
      if (!bad)
         n_legal++;
      exp_q.push_back(e);
      instr_i       = ins;
      instr_valid_i = 1'b1;
      step();
      instr_valid_i = 1'b0;
   endtask

   task automatic op_r(input logic [6:0] f7, input logic [2:0] f3, input int rd, rs1, rs2);
      issue({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], cpu_pkg::OPC_OP}, 1'b0);
   endtask

   task automatic op_i(input logic [11:0] imm, input logic [2:0] f3, input int rd, rs1);
      issue({imm, rs1[4:0], f3, rd[4:0], cpu_pkg::OPC_OP_IMM}, 1'b0);
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
         step();
   endtask

   // debug port against the model once the pipe is empty
   task automatic readback(input int lo, input int hi);
      drain();
      for (int r = lo; r <= hi; r++)
      begin
         dbg_addr_i = r[4:0];
         #2;
         check_val($sformatf("dbg_data_o x%0d", r), dbg_data_o, model_regs[r]);
         step();
      end
   endtask

   // oldest expectation against the retire outputs
   task automatic check_retire();
      retire_t e;
      n_checks++;
      assert (exp_q.size() != 0)
      else
      begin
         $display("retire_o pulsed with no instruction outstanding");
         n_errors++;
      end
      if (exp_q.size() == 0)
         return;
      e = exp_q.pop_front();
      n_checks++;
      assert (32'(n_cycles) == e.due)
      else
      begin
         $display("retire of x%0d came in cycle %0d instead of cycle %0d",
                  e.rd, n_cycles, e.due);
         n_errors++;
      end
      check_val("illegal_o", 32'(illegal_o), 32'(e.illegal));
      check_val("retire_we_o", 32'(retire_we_o), 32'(e.we));
      if (!e.illegal)
      begin
         check_val("retire_rd_o", 32'(retire_rd_o), 32'(e.rd));
         check_val("retire_data_o", retire_data_o, e.data);
      end
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (n_errors == last_errs)
         $display("test %s: ok", name);
      else
      begin
         n_failed++;
         $display("test %s: failed with %0d errors", name, n_errors - last_errs);
      end
      last_errs = n_errors;
   endtask

   // ################################################
   // tests
   // ################################################
   task automatic reset_state();
      check_val("retire_o", 32'(retire_o), 32'h0);
      check_val("illegal_o", 32'(illegal_o), 32'h0);
      check_val("instret_o", instret_o, 32'h0);
      readback(0, 31);                                // all regs cleared
      end_test("reset state");
   endtask

   task automatic reg_reg_ops();
      op_i(12'd100, cpu_pkg::F3_ADD_SUB, 1, 0);
      op_i(12'hff9, cpu_pkg::F3_ADD_SUB, 2, 0);       // x2 = -7
      op_i(12'd5,   cpu_pkg::F3_ADD_SUB, 3, 0);       // shift amount
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_ADD_SUB,  5, 1, 2);
      op_r(cpu_pkg::F7_ALT,  cpu_pkg::F3_ADD_SUB,  6, 1, 2);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_SLL,      7, 1, 3);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_SLT,      8, 2, 1);  // -7 < 100 when signed
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_SLTU,     9, 2, 1);  // -7 is huge when unsigned
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_XOR,     10, 1, 2);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_SRL_SRA, 11, 2, 3);
      op_r(cpu_pkg::F7_ALT,  cpu_pkg::F3_SRL_SRA, 12, 2, 3);  // sra of negative
      op_r(cpu_pkg::F7_ALT,  cpu_pkg::F3_SRL_SRA, 13, 1, 3);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_OR,      14, 1, 2);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_AND,     15, 1, 2);
      readback(1, 15);
      end_test("register-register ops");
   endtask

   task automatic imm_ops();
      op_i(12'hf9c, cpu_pkg::F3_ADD_SUB, 16, 1);      // 100 - 100
      op_i(12'hffa, cpu_pkg::F3_SLT,     17, 2);
      op_i(12'hfff, cpu_pkg::F3_SLTU,    18, 2);      // imm extends to all ones
      op_i(12'hfff, cpu_pkg::F3_XOR,     19, 1);
      op_i(12'h0f0, cpu_pkg::F3_OR,      20, 2);
      op_i(12'h7ff, cpu_pkg::F3_AND,     21, 2);
      op_i(12'h01f, cpu_pkg::F3_SLL,     22, 1);
      op_i(12'h000, cpu_pkg::F3_SLL,     23, 2);
      op_i(12'h01f, cpu_pkg::F3_SRL_SRA, 24, 2);
      op_i(12'h000, cpu_pkg::F3_SRL_SRA, 25, 2);
      op_i(12'h41f, cpu_pkg::F3_SRL_SRA, 26, 2);      // srai 31
      op_i(12'h400, cpu_pkg::F3_SRL_SRA, 27, 2);      // srai 0
      readback(16, 27);
      end_test("immediate ops");
   endtask

   task automatic forwarding_chain();
      op_i(12'd3, cpu_pkg::F3_ADD_SUB, 28, 1);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_ADD_SUB, 29, 28, 28);  // each one needs the last
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_ADD_SUB, 30, 29, 29);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_SLL,     31, 30, 30);
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_ADD_SUB, 28, 31, 31);
      op_r(cpu_pkg::F7_ALT,  cpu_pkg::F3_SRL_SRA, 29, 28, 28);
      readback(28, 31);
      end_test("forwarding");
   endtask

   task automatic reg_zero();
      op_i(12'd55, cpu_pkg::F3_ADD_SUB, 0, 1);                 // retires 155 but x0 keeps 0
      op_r(cpu_pkg::F7_BASE, cpu_pkg::F3_ADD_SUB, 7, 0, 1);   // x0 must not forward
      op_r(cpu_pkg::F7_ALT,  cpu_pkg::F3_ADD_SUB, 8, 0, 2);
      readback(0, 8);
      end_test("register zero");
   endtask

   task automatic illegal_and_instret();
      op_i(12'd1, cpu_pkg::F3_ADD_SUB, 9, 0);
      issue(32'h0000_0483, 1'b1);                     // lb x9
      issue({7'h01, 5'd2, 5'd1, cpu_pkg::F3_ADD_SUB, 5'd9, cpu_pkg::OPC_OP}, 1'b1);  // mul
      op_i(12'd4, cpu_pkg::F3_OR, 11, 9);
      issue({12'h41f, 5'd1, cpu_pkg::F3_SLL, 5'd9, cpu_pkg::OPC_OP_IMM}, 1'b1);
      issue({cpu_pkg::F7_ALT, 5'd2, 5'd1, cpu_pkg::F3_XOR, 5'd9, cpu_pkg::OPC_OP}, 1'b1);
      issue(32'hffff_ffff, 1'b1);
      op_i(12'd2, cpu_pkg::F3_ADD_SUB, 10, 9);        // right behind an illegal
      readback(9, 31);
      check_val("instret_o", instret_o, n_legal);
      end_test("illegal encodings");
   endtask

   task automatic random_stream();
      logic        imm_sel, alt;
      logic [2:0]  f3;
      logic [11:0] imm;
      int          rd, rs1, rs2;
      for (int i = 0; i < 200; i++)
      begin
         imm_sel = 1'(rand_bits(1));
         f3      = 3'(rand_bits(3));
         rd      = int'(rand_bits(5));
         rs1     = int'(rand_bits(5));
         alt     = rand_bits(1) != 0 &&
                   (f3 == cpu_pkg::F3_ADD_SUB || f3 == cpu_pkg::F3_SRL_SRA);
         if (imm_sel)
         begin
            imm = 12'(rand_bits(12));
            if (f3 == cpu_pkg::F3_SLL || f3 == cpu_pkg::F3_SRL_SRA)
               imm[11:5] = alt ? cpu_pkg::F7_ALT : cpu_pkg::F7_BASE;  // legal shamt form
            op_i(imm, f3, rd, rs1);
         end
         else
         begin
            rs2 = int'(rand_bits(5));
            op_r(alt ? cpu_pkg::F7_ALT : cpu_pkg::F7_BASE, f3, rd, rs1, rs2);
         end
         if (rand_bits(1) != 0)
            step();                                   // one idle cycle
      end
      readback(0, 31);
      check_val("instret_o", instret_o, n_legal);
      end_test("random stream");
   endtask

   // ################################################
   // monitor, timeout, sequence
   // ################################################
   initial
   begin
      forever
      begin
         @(posedge clk);
         #2;                                          // outputs settled after the edge
         if (retire_o === 1'b1)
            check_retire();
      end
   end

   initial
   begin
      n_cycles = 0;
      while (n_cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         n_cycles++;
      end
      $display("timeout after %0d cycles, tests did not complete", n_cycles);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      reset_i       = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      dbg_addr_i    = '0;
      lfsr          = 32'd75;                         // seed
      repeat (2) @(posedge clk);
      #1;
      reset_i = 1'b0;
      reset_state();
      reg_reg_ops();
      imm_ops();
      forwarding_chain();
      reg_zero();
      illegal_and_instret();
      random_stream();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               n_tests, n_failed, n_checks, n_errors);
      if (n_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- all.f
cpu_pkg.sv
regfile.sv
id_stage.sv
ex.sv
wb_stage.sv
exec_core.sv
tb_exec_core.sv
